/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rs_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ooo_pkg.sv */
package ooo_pkg;

  // datapath word and reorder buffer tag widths
  localparam int gpr_size     = 64;
  localparam int rob_idx_size = 5;

  // which station an instruction is steered to
  typedef enum logic {
    fu_alu,
    fu_ls
  } fu_t;

  // opcodes carried through the stations untouched
  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_orr,
    op_eor,
    op_ldr,
    op_str
  } alu_op_t;

  // condition flags
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

  // one source operand, either a value or the rob tag producing it
  typedef struct packed {
    logic                    valid;
    logic [gpr_size-1:0]     value;
    logic [rob_idx_size-1:0] rob_index;
  } operand_t;

  // one dispatched instruction as held in a station slot
  typedef struct packed {
    alu_op_t                 op;
    operand_t                op_a;
    operand_t                op_b;
    logic [rob_idx_size-1:0] dst_rob_index;
    logic                    needs_nzcv;
    logic                    nzcv_valid;
    nzcv_t                   nzcv;
    logic [rob_idx_size-1:0] nzcv_rob_index;
    logic                    set_nzcv;
  } rs_entry_t;

  // what a functional unit receives on issue
  typedef struct packed {
    alu_op_t                 op;
    logic [gpr_size-1:0]     val_a;
    logic [gpr_size-1:0]     val_b;
    logic [rob_idx_size-1:0] dst_rob_index;
    nzcv_t                   nzcv;
    logic                    set_nzcv;
  } issue_t;

  // capture a broadcast value into an operand still waiting on that tag
  function automatic operand_t wake_operand(input operand_t opnd, input logic bus_valid,
                                            input logic [rob_idx_size-1:0] bus_index,
                                            input logic [gpr_size-1:0] bus_value);
    wake_operand = opnd;
    if (bus_valid && !opnd.valid && opnd.rob_index == bus_index) begin
      wake_operand.valid = 1'b1;
      wake_operand.value = bus_value;
    end
  endfunction

  // apply one cdb broadcast to every waiting field of an entry
  function automatic rs_entry_t wake_entry(input rs_entry_t entry, input logic bus_valid,
                                           input logic [rob_idx_size-1:0] bus_index,
                                           input logic [gpr_size-1:0] bus_value,
                                           input logic bus_set_nzcv, input nzcv_t bus_nzcv);
    wake_entry      = entry;
    wake_entry.op_a = wake_operand(entry.op_a, bus_valid, bus_index, bus_value);
    wake_entry.op_b = wake_operand(entry.op_b, bus_valid, bus_index, bus_value);
    // flags only come from a producer that actually writes them
    if (bus_valid && bus_set_nzcv && entry.needs_nzcv && !entry.nzcv_valid &&
        entry.nzcv_rob_index == bus_index) begin
      wake_entry.nzcv_valid = 1'b1;
      wake_entry.nzcv       = bus_nzcv;
    end
  endfunction

endpackage

/* reservation_station.sv */
module reservation_station #(
  parameter int rs_size = 4
) (
  input  logic               in_clk,
  input  logic               in_rst,
  input  logic               flush,
  // write port from dispatch
  input  logic               write,
  input  ooo_pkg::rs_entry_t write_entry,
  output logic               full,
  // wakeup source
  rs_cdb_if.listener         cdb,
  // four-phase issue to the functional unit
  output logic               issue_req,
  output ooo_pkg::issue_t    issue_data,
  input  logic               issue_ack
);
  import ooo_pkg::*;

  // slot index width, at least one bit
  localparam int idx_w = (rs_size > 1) ? $clog2(rs_size) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_requesting,
    st_draining
  } issue_state_t;

  // slot payload
  rs_entry_t          entries [rs_size];
  // per-slot occupancy
  logic [rs_size-1:0] occupied;
  logic [rs_size-1:0] ready;
  logic [idx_w-1:0]   free_idx;
  logic [idx_w-1:0]   ready_idx;
  // slot currently offered to the functional unit
  logic [idx_w-1:0]   issue_idx;
  logic               ready_found;
  logic               do_write;
  logic               start_issue;
  issue_state_t       state;

  // priority select, lowest set bit wins
  function automatic logic [idx_w-1:0] lowest_set(input logic [rs_size-1:0] bits);
    lowest_set = '0;
    for (int i = rs_size - 1; i >= 0; i--) begin
      if (bits[i]) begin
        lowest_set = idx_w'(i);
      end
    end
  endfunction

  // ready once both operands are in, and flags too when they are needed
  always_comb begin
    for (int i = 0; i < rs_size; i++) begin
      ready[i] = occupied[i] && entries[i].op_a.valid && entries[i].op_b.valid &&
                 (!entries[i].needs_nzcv || entries[i].nzcv_valid);
    end
  end

  assign full        = &occupied;
  assign free_idx    = lowest_set(~occupied);
  assign ready_idx   = lowest_set(ready);
  assign ready_found = |ready;

  // dispatch never writes into a full station, the guard keeps slots safe anyway
  assign do_write = write && !full;

  // pick a new entry only with the fu's ack back at zero
  assign start_issue = (state == st_idle) && ready_found && !issue_ack;

  assign issue_req = (state == st_requesting);

  // payload path
  always_ff @(posedge in_clk) begin
    // every stored field snoops the bus each cycle
    // this keeps going while the fu stalls
    for (int i = 0; i < rs_size; i++) begin
      entries[i] <= wake_entry(entries[i], cdb.valid, cdb.rob_index, cdb.value,
                               cdb.set_nzcv, cdb.nzcv);
    end
    // new entry lands in the lowest free slot
    if (do_write) begin
      entries[free_idx] <= write_entry;
    end
    // latch the chosen entry, held while issue_req is up
    if (start_issue) begin
      issue_idx                <= ready_idx;
      issue_data.op            <= entries[ready_idx].op;
      issue_data.val_a         <= entries[ready_idx].op_a.value;
      issue_data.val_b         <= entries[ready_idx].op_b.value;
      issue_data.dst_rob_index <= entries[ready_idx].dst_rob_index;
      issue_data.nzcv          <= entries[ready_idx].nzcv;
      issue_data.set_nzcv      <= entries[ready_idx].set_nzcv;
    end
  end

  // occupancy and issue handshake
  always_ff @(posedge in_clk) begin
    if (in_rst || flush) begin
      // flush drops everything, including a write in the same cycle
      occupied <= '0;
      state    <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (start_issue) begin
            state <= st_requesting;
          end
        end
        // entry stays occupied until the fu takes it
        st_requesting: begin
          if (issue_ack) begin
            occupied[issue_idx] <= 1'b0;
            state               <= st_draining;
          end
        end
        // wait for the fu to drop ack before the next request
        st_draining: begin
          if (!issue_ack) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
      // the write slot is free, so it never collides with the freed one
      if (do_write) begin
        occupied[free_idx] <= 1'b1;
      end
    end
  end

endmodule

/* rs_cdb_if.sv */
interface rs_cdb_if;
  import ooo_pkg::*;

  // broadcast from the rob, no handshake
  logic                    valid;
  logic [rob_idx_size-1:0] rob_index;
  logic [gpr_size-1:0]     value;
  // flags are only meaningful with set_nzcv high
  logic                    set_nzcv;
  nzcv_t                   nzcv;

  // the rob side drives the bus
  modport source (
    output valid, rob_index, value, set_nzcv, nzcv
  );

  // dispatch and stations snoop it
  modport listener (
    input valid, rob_index, value, set_nzcv, nzcv
  );

endinterface

/* rs_dispatch.sv */
module rs_dispatch (
  input  logic               in_clk,
  input  logic               in_rst,
  // rob side, four-phase
  input  logic               dispatch_req,
  input  ooo_pkg::fu_t       dispatch_fu,
  input  ooo_pkg::rs_entry_t dispatch_entry,
  output logic               dispatch_ack,
  // broadcast snoop for the capture cycle
  rs_cdb_if.listener         cdb,
  // station side
  input  logic               alu_full,
  input  logic               ls_full,
  output logic               alu_write,
  output logic               ls_write,
  output ooo_pkg::rs_entry_t write_entry
);
  import ooo_pkg::*;

  // handshake phases with the rob
  typedef enum logic [1:0] {
    st_idle,
    st_wait_space,
    st_acked,
    st_release
  } dispatch_state_t;

  dispatch_state_t state;
  dispatch_state_t state_next;
  logic            target_full;
  logic            accepting;
  logic            capture;

  // full flag of whichever station the instruction goes to
  assign target_full = (dispatch_fu == fu_alu) ? alu_full : ls_full;

  // ack low in every state but acked, so a held request may be taken
  assign accepting = (state != st_acked);
  assign capture   = accepting && dispatch_req && !target_full;

  // one-cycle write strobe to the chosen station
  assign alu_write = capture && (dispatch_fu == fu_alu);
  assign ls_write  = capture && (dispatch_fu == fu_ls);

  // merge a broadcast landing in the capture cycle
  // otherwise the station would store a stale tag and miss it
  assign write_entry = wake_entry(dispatch_entry, cdb.valid, cdb.rob_index, cdb.value,
                                  cdb.set_nzcv, cdb.nzcv);

  assign dispatch_ack = (state == st_acked);

  always_comb begin
    state_next = state;
    case (state)
      // release is the return-to-zero phase, a new request may already wait
      st_idle, st_release: begin
        if (capture) begin
          state_next = st_acked;
        end else if (dispatch_req) begin
          state_next = st_wait_space;
        end else begin
          state_next = st_idle;
        end
      end
      // station full, rob keeps the request up
      st_wait_space: begin
        if (capture) begin
          state_next = st_acked;
        end else if (!dispatch_req) begin
          state_next = st_idle;
        end
      end
      // hold ack until the rob drops its request
      st_acked: begin
        if (!dispatch_req) begin
          state_next = st_release;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* rs_top.sv */
module rs_top #(
  parameter int alu_rs_size = 8,
  parameter int ls_rs_size  = 4
) (
  input  logic                                in_clk,
  input  logic                                in_rst,
  input  logic                                flush,
  // dispatch from the rob
  input  logic                                dispatch_req,
  input  ooo_pkg::fu_t                        dispatch_fu,
  input  ooo_pkg::rs_entry_t                  dispatch_entry,
  output logic                                dispatch_ack,
  // common data bus
  input  logic                                cdb_valid,
  input  logic [ooo_pkg::rob_idx_size-1:0]    cdb_rob_index,
  input  logic [ooo_pkg::gpr_size-1:0]        cdb_value,
  input  logic                                cdb_set_nzcv,
  input  ooo_pkg::nzcv_t                      cdb_nzcv,
  // alu issue
  output logic                                alu_issue_req,
  output ooo_pkg::issue_t                     alu_issue_data,
  input  logic                                alu_issue_ack,
  // load/store issue
  output logic                                ls_issue_req,
  output ooo_pkg::issue_t                     ls_issue_data,
  input  logic                                ls_issue_ack
);
  import ooo_pkg::*;

  // station back-pressure and write strobes
  logic      alu_full;
  logic      ls_full;
  logic      alu_write;
  logic      ls_write;
  // one entry bus shared by both stations, the strobe picks the target
  rs_entry_t write_entry;

  rs_cdb_if cdb_bus ();

  // drive the broadcast bus from the top-level pins
  assign cdb_bus.valid     = cdb_valid;
  assign cdb_bus.rob_index = cdb_rob_index;
  assign cdb_bus.value     = cdb_value;
  assign cdb_bus.set_nzcv  = cdb_set_nzcv;
  assign cdb_bus.nzcv      = cdb_nzcv;

  rs_dispatch dispatch_i (
    .in_clk        (in_clk),
    .in_rst        (in_rst),
    .dispatch_req  (dispatch_req),
    .dispatch_fu   (dispatch_fu),
    .dispatch_entry(dispatch_entry),
    .dispatch_ack  (dispatch_ack),
    .cdb           (cdb_bus.listener),
    .alu_full      (alu_full),
    .ls_full       (ls_full),
    .alu_write     (alu_write),
    .ls_write      (ls_write),
    .write_entry   (write_entry)
  );

  reservation_station #(
    .rs_size(alu_rs_size)
  ) alu_rs (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .flush      (flush),
    .write      (alu_write),
    .write_entry(write_entry),
    .full       (alu_full),
    .cdb        (cdb_bus.listener),
    .issue_req  (alu_issue_req),
    .issue_data (alu_issue_data),
    .issue_ack  (alu_issue_ack)
  );

  reservation_station #(
    .rs_size(ls_rs_size)
  ) ls_rs (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .flush      (flush),
    .write      (ls_write),
    .write_entry(write_entry),
    .full       (ls_full),
    .cdb        (cdb_bus.listener),
    .issue_req  (ls_issue_req),
    .issue_data (ls_issue_data),
    .issue_ack  (ls_issue_ack)
  );

endmodule

/* sim.f */
ooo_pkg.sv
rs_cdb_if.sv
rs_dispatch.sv
reservation_station.sv
rs_top.sv
tb_rs_top.sv

/* tb_rs_top.sv */
module tb_rs_top;
  timeunit 1ns;
  timeprecision 1ps;
  import ooo_pkg::*;

  localparam int num_tests = 6;
  localparam int ls_depth  = 4;

  logic                    in_clk;
  logic                    in_rst;
  logic                    flush;
  logic                    dispatch_req;
  fu_t                     dispatch_fu;
  rs_entry_t               dispatch_entry;
  logic                    dispatch_ack;
  logic                    cdb_valid;
  logic [rob_idx_size-1:0] cdb_rob_index;
  logic [gpr_size-1:0]     cdb_value;
  logic                    cdb_set_nzcv;
  nzcv_t                   cdb_nzcv;
  logic                    alu_issue_req;
  issue_t                  alu_issue_data;
  logic                    alu_issue_ack;
  logic                    ls_issue_req;
  issue_t                  ls_issue_data;
  logic                    ls_issue_ack;

  int    errors       = 0;
  int    failed_tests = 0;
  int    test_errors;
  string test_name;
  // issue count per destination tag
  int    issued [32];

  rs_top #(
    .alu_rs_size(8),
    .ls_rs_size (ls_depth)
  ) dut_i (.*);

  initial begin
    in_clk = 1'b0;
    forever #50 in_clk = ~in_clk;
  end

  // ends a run that stopped making progress
  initial begin
    #(num_tests * 200 * 100);
    $display("watchdog: the run did not finish in %0d cycles", num_tests * 200);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_issue(input string what, input issue_t exp, input issue_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  // operand a waits on tag and operand b on tag + 1 with random values
  function automatic rs_entry_t make_entry(input alu_op_t op, input logic [rob_idx_size-1:0] dst,
                                           input logic a_wait, input logic b_wait,
                                           input logic [rob_idx_size-1:0] tag);
    rs_entry_t e;
    e                = '0;
    e.op             = op;
    e.op_a.valid     = !a_wait;
    e.op_a.value     = {$urandom, $urandom};
    e.op_a.rob_index = tag;
    e.op_b.valid     = !b_wait;
    e.op_b.value     = {$urandom, $urandom};
    e.op_b.rob_index = tag + 1'b1;
    e.dst_rob_index  = dst;
    e.nzcv_valid     = 1'b1;
    e.nzcv           = nzcv_t'(4'($urandom));
    e.set_nzcv       = 1'($urandom);
    return e;
  endfunction

  // what the fu should see with operand and flag values resolved by the test
  function automatic issue_t expected_issue(input rs_entry_t e, input logic [gpr_size-1:0] a,
                                            input logic [gpr_size-1:0] b, input nzcv_t f);
    issue_t i;
    i.op            = e.op;
    i.val_a         = a;
    i.val_b         = b;
    i.dst_rob_index = e.dst_rob_index;
    i.nzcv          = f;
    i.set_nzcv      = e.set_nzcv;
    return i;
  endfunction

  function automatic logic issue_req_of(input fu_t fu);
    return (fu == fu_alu) ? alu_issue_req : ls_issue_req;
  endfunction

  task automatic drive_ack(input fu_t fu, input logic level);
    if (fu == fu_alu) begin
      alu_issue_ack <= level;
    end else begin
      ls_issue_ack <= level;
    end
  endtask

  // rob model
  task automatic raise_dispatch(input fu_t fu, input rs_entry_t e);
    @(posedge in_clk);
    dispatch_req   <= 1'b1;
    dispatch_fu    <= fu;
    dispatch_entry <= e;
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    do begin
      @(negedge in_clk);
      n++;
    end while (dispatch_ack !== level && n < 50);
    if (dispatch_ack !== level) begin
      report_failure("dispatch_ack never reached the expected level");
    end
  endtask

  // request drops only after the ack and the ack must follow it down
  task automatic finish_dispatch();
    wait_ack(1'b1);
    @(posedge in_clk);
    dispatch_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic dispatch(input fu_t fu, input rs_entry_t e);
    raise_dispatch(fu, e);
    finish_dispatch();
  endtask

  // one cycle on the cdb
  task automatic broadcast(input logic [rob_idx_size-1:0] tag, input logic [gpr_size-1:0] value,
                           input logic set, input nzcv_t f);
    @(posedge in_clk);
    cdb_valid     <= 1'b1;
    cdb_rob_index <= tag;
    cdb_value     <= value;
    cdb_set_nzcv  <= set;
    cdb_nzcv      <= f;
    @(posedge in_clk);
    cdb_valid <= 1'b0;
  endtask

  // fu model that waits up to max_cycles for a request and runs the four phases
  task automatic take_issue(input fu_t fu, input int max_cycles, output issue_t data,
                            output bit got);
    int n;
    got  = 1'b0;
    data = '0;
    n    = 0;
    while (!got && n < max_cycles) begin
      @(negedge in_clk);
      n++;
      got  = issue_req_of(fu);
      data = (fu == fu_alu) ? alu_issue_data : ls_issue_data;
    end
    if (got) begin
      @(posedge in_clk);
      drive_ack(fu, 1'b1);
      n = 0;
      do begin
        @(negedge in_clk);
        n++;
      end while (issue_req_of(fu) && n < 20);
      if (issue_req_of(fu)) begin
        report_failure("issue_req stayed high after the ack");
      end
      @(posedge in_clk);
      drive_ack(fu, 1'b0);
    end
  endtask

  task automatic expect_issue(input fu_t fu, input issue_t exp);
    issue_t d;
    bit     got;
    take_issue(fu, 30, d, got);
    check_bit("issue_req", 1'b1, got);
    if (got) begin
      check_issue("issue_data", exp, d);
    end
  endtask

  task automatic expect_no_issue(input fu_t fu, input int cycles);
    issue_t d;
    bit     got;
    take_issue(fu, cycles, d, got);
    check_bit("unexpected issue_req", 1'b0, got);
  endtask

  task automatic test_routing();
    rs_entry_t ea;
    rs_entry_t el;
    begin_test("routing");
    check_bit("dispatch_ack after reset", 1'b0, dispatch_ack);
    check_bit("alu_issue_req after reset", 1'b0, alu_issue_req);
    check_bit("ls_issue_req after reset", 1'b0, ls_issue_req);
    ea = make_entry(op_add, 5'd1, 1'b0, 1'b0, 5'd0);
    el = make_entry(op_ldr, 5'd2, 1'b0, 1'b0, 5'd0);
    dispatch(fu_alu, ea);
    dispatch(fu_ls, el);
    expect_issue(fu_alu, expected_issue(ea, ea.op_a.value, ea.op_b.value, ea.nzcv));
    expect_issue(fu_ls, expected_issue(el, el.op_a.value, el.op_b.value, el.nzcv));
    // each one issues exactly once
    expect_no_issue(fu_alu, 10);
    expect_no_issue(fu_ls, 10);
    end_test();
  endtask

  task automatic test_wakeup();
    rs_entry_t          e;
    logic [gpr_size-1:0] va;
    logic [gpr_size-1:0] vb;
    begin_test("wakeup");
    va = {$urandom, $urandom};
    vb = {$urandom, $urandom};
    e  = make_entry(op_sub, 5'd3, 1'b1, 1'b1, 5'd10);
    dispatch(fu_alu, e);
    expect_no_issue(fu_alu, 8);
    broadcast(5'd10, va, 1'b0, '0);
    // still one operand short
    expect_no_issue(fu_alu, 5);
    broadcast(5'd11, vb, 1'b0, '0);
    expect_issue(fu_alu, expected_issue(e, va, vb, e.nzcv));
    end_test();
  endtask

  task automatic test_flags();
    rs_entry_t e;
    begin_test("flags");
    e                = make_entry(op_add, 5'd4, 1'b0, 1'b0, 5'd0);
    e.needs_nzcv     = 1'b1;
    e.nzcv_valid     = 1'b0;
    e.nzcv_rob_index = 5'd12;
    dispatch(fu_alu, e);
    // producer without set_nzcv does not supply flags
    broadcast(5'd12, 64'd0, 1'b0, nzcv_t'(4'hf));
    expect_no_issue(fu_alu, 8);
    broadcast(5'd12, 64'd0, 1'b1, nzcv_t'(4'h6));
    expect_issue(fu_alu, expected_issue(e, e.op_a.value, e.op_b.value, nzcv_t'(4'h6)));
    end_test();
  endtask

  task automatic test_backpressure();
    rs_entry_t e;
    issue_t    d;
    bit        got;
    int        total;
    begin_test("backpressure");
    issued = '{default: 0};
    total  = 0;
    // every slot waits on its own tag
    for (int i = 0; i < ls_depth; i++) begin
      e = make_entry(op_ldr, 5'(20 + i), 1'b1, 1'b0, 5'(16 + i));
      dispatch(fu_ls, e);
    end
    e = make_entry(op_str, 5'd25, 1'b1, 1'b0, 5'd24);
    raise_dispatch(fu_ls, e);
    repeat (6) begin
      @(negedge in_clk);
      check_bit("dispatch_ack while full", 1'b0, dispatch_ack);
    end
    // the freed slot lets the held dispatch through
    fork
      begin
        broadcast(5'd16, 64'd0, 1'b0, '0);
        take_issue(fu_ls, 20, d, got);
        if (got) begin
          issued[d.dst_rob_index]++;
          total++;
        end
      end
      finish_dispatch();
    join
    for (int t = 17; t < 20; t++) begin
      broadcast(5'(t), 64'd0, 1'b0, '0);
    end
    broadcast(5'd24, 64'd0, 1'b0, '0);
    repeat (4) begin
      take_issue(fu_ls, 30, d, got);
      if (got) begin
        issued[d.dst_rob_index]++;
        total++;
      end
    end
    check_count("issues in total", 5, total);
    for (int t = 20; t < 24; t++) begin
      check_count($sformatf("issues of dst %0d", t), 1, issued[t]);
    end
    check_count("issues of dst 25", 1, issued[25]);
    end_test();
  endtask

  task automatic test_bypass();
    rs_entry_t           e;
    logic [gpr_size-1:0] v;
    begin_test("bypass");
    v = {$urandom, $urandom};
    e = make_entry(op_orr, 5'd27, 1'b1, 1'b0, 5'd26);
    raise_dispatch(fu_alu, e);
    // broadcast covers only the capture cycle
    cdb_valid     <= 1'b1;
    cdb_rob_index <= 5'd26;
    cdb_value     <= v;
    cdb_set_nzcv  <= 1'b0;
    // gone by the edge that raises dispatch_ack
    @(posedge in_clk);
    cdb_valid <= 1'b0;
    finish_dispatch();
    // no later broadcast so only the bypassed value can wake it
    expect_issue(fu_alu, expected_issue(e, v, e.op_b.value, e.nzcv));
    end_test();
  endtask

  task automatic test_flush();
    rs_entry_t ea;
    rs_entry_t el;
    begin_test("flush");
    ea = make_entry(op_eor, 5'd30, 1'b1, 1'b0, 5'd28);
    el = make_entry(op_ldr, 5'd31, 1'b1, 1'b0, 5'd29);
    dispatch(fu_alu, ea);
    dispatch(fu_ls, el);
    @(posedge in_clk);
    flush <= 1'b1;
    @(posedge in_clk);
    flush <= 1'b0;
    // these tags would have woken both entries
    broadcast(5'd28, 64'd0, 1'b0, '0);
    broadcast(5'd29, 64'd0, 1'b0, '0);
    expect_no_issue(fu_alu, 20);
    expect_no_issue(fu_ls, 20);
    // station still usable afterwards
    ea = make_entry(op_add, 5'd5, 1'b0, 1'b0, 5'd0);
    dispatch(fu_alu, ea);
    expect_issue(fu_alu, expected_issue(ea, ea.op_a.value, ea.op_b.value, ea.nzcv));
    end_test();
  endtask

  initial begin
    void'($urandom(32'h5520));
    in_rst         = 1'b1;
    flush          = 1'b0;
    dispatch_req   = 1'b0;
    dispatch_fu    = fu_alu;
    dispatch_entry = '0;
    cdb_valid      = 1'b0;
    cdb_rob_index  = '0;
    cdb_value      = '0;
    cdb_set_nzcv   = 1'b0;
    cdb_nzcv       = '0;
    alu_issue_ack  = 1'b0;
    ls_issue_ack   = 1'b0;
    repeat (2) @(posedge in_clk);
    in_rst <= 1'b0;
    @(negedge in_clk);
    test_routing();
    test_wakeup();
    test_flags();
    test_backpressure();
    test_bypass();
    test_flush();
    $display("summary: %0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
